//--- verilog/pong_pkg.sv
// shared definitions for the pong design
// geometry defaults, colours, pixel and coordinate types, source modes
`default_nettype none

package pong_pkg;

   // 1024x768 raster, 1344 clocks per line, 806 lines per frame
   localparam int H_ACTIVE_DEF = 1024;
   localparam int H_FRONT_DEF = 24;
   localparam int H_SYNC_DEF = 136;
   localparam int H_BACK_DEF = 160;
   localparam int V_ACTIVE_DEF = 768;
   localparam int V_FRONT_DEF = 9;
   localparam int V_SYNC_DEF = 6;
   localparam int V_BACK_DEF = 23;

   // game objects, in pixels
   localparam int PADDLE_H_DEF = 128;
   localparam int PADDLE_W_DEF = 16;
   localparam int PADDLE_STEP_DEF = 4;
   localparam int PUCK_DIM_DEF = 64;
   localparam int SQUARE_DIM_DEF = 128;

   // button filter length in clocks, and colour bar position in hcount
   localparam int DEBOUNCE_DEF = 650000;
   localparam int BAR_SHIFT_DEF = 6;

   // puck weight in the blend, out of 256
   localparam int ALPHA = 128;

   typedef logic [23:0] pixel_t;
   typedef logic [10:0] hcoord_t;
   typedef logic [9:0] vcoord_t;

   // red in the high byte
   localparam pixel_t COLOR_PADDLE = 24'hFF_FF_00;
   localparam pixel_t COLOR_PUCK = 24'hFF_FF_FF;
   localparam pixel_t COLOR_SQUARE = 24'hFF_00_00;

   // code 3 is unnamed and shows the game as well
   typedef enum logic [1:0] {
      SRC_PONG = 2'b00,
      SRC_OUTLINE = 2'b01,
      SRC_BARS = 2'b10
   } source_mode_t;

endpackage

`default_nettype wire

//--- verilog/pong_interfaces.sv
// raster, paddle button and game state interfaces
`default_nettype none

// raster counts, syncs and frame marker from the timing generator
interface raster_if;
   import pong_pkg::*;

   hcoord_t hcount;
   vcoord_t vcount;
   // syncs are active low
   logic hsync;
   logic vsync;
   logic blank;
   // one clock wide, on the vsync fall
   logic frame_tick;

   modport source (output hcount, vcount, hsync, vsync, blank, frame_tick);
   modport sink (input hcount, vcount, hsync, vsync, blank, frame_tick);
endinterface

// debounced paddle requests, active high
// up/down steer the left paddle, left/right the right paddle
interface paddle_if;
   logic up;
   logic down;
   logic left;
   logic right;

   modport source (output up, down, left, right);
   modport sink (input up, down, left, right);
endinterface

// positions of the moving objects, top left corners
interface game_if;
   import pong_pkg::*;

   vcoord_t paddle_y;
   vcoord_t paddle_2_y;
   hcoord_t puck_x;
   vcoord_t puck_y;

   modport source (output paddle_y, paddle_2_y, puck_x, puck_y);
   modport sink (input paddle_y, paddle_2_y, puck_x, puck_y);
endinterface

`default_nettype wire

//--- verilog/button_debounce.sv
// counter debouncer for a single button
`default_nettype none

module button_debounce #(
   parameter int DEBOUNCE = 650000
) (
   input  logic clock,
   input  logic reset,
   input  logic noisy,
   output logic clean
);

   localparam int CW = $clog2(DEBOUNCE + 1);

   logic [CW-1:0] count;
   // last sampled input level
   logic sample;

   // any change of the input restarts the count
   always_ff @(posedge clock) begin
      if (reset) begin
         sample <= noisy;
         clean <= noisy;
         count <= '0;
      end else if (noisy != sample) begin
         sample <= noisy;
         count <= '0;
      end else if (count == CW'(DEBOUNCE)) begin
         clean <= sample;
      end else begin
         count <= count + 1'b1;
      end
   end

   // output only moves once the input has held still long enough
   assert property (@(posedge clock) disable iff (reset)
      $changed(clean) |-> $past(count == CW'(DEBOUNCE)) || $past(reset));

endmodule

`default_nettype wire

//--- verilog/paddle_buttons.sv
// input side of the game
// inverts and debounces the four paddle buttons
`default_nettype none

module paddle_buttons #(
   parameter int DEBOUNCE = 650000
) (
   input  logic clock,
   input  logic reset,
   input  logic button_up_n,
   input  logic button_down_n,
   input  logic button_left_n,
   input  logic button_right_n,
   paddle_if.source buttons
);

   logic [3:0] pressed;
   logic [3:0] filtered;

   // board buttons pull low when pressed
   assign pressed = ~{button_up_n, button_down_n, button_left_n, button_right_n};

   for (genvar i = 0; i < 4; i++) begin : g_debounce
      button_debounce #(.DEBOUNCE(DEBOUNCE)) debounce_inst (
         .clock(clock),
         .reset(reset),
         .noisy(pressed[i]),
         .clean(filtered[i])
      );
   end

   assign buttons.up = filtered[3];
   assign buttons.down = filtered[2];
   assign buttons.left = filtered[1];
   assign buttons.right = filtered[0];

endmodule

`default_nettype wire

//--- verilog/raster_timing.sv
// raster timing generator
// pixel and line counters, active-low syncs, blanking, frame-start pulse
`default_nettype none

module raster_timing #(
   parameter int H_ACTIVE = 1024,
   parameter int H_FRONT = 24,
   parameter int H_SYNC = 136,
   parameter int H_BACK = 160,
   parameter int V_ACTIVE = 768,
   parameter int V_FRONT = 9,
   parameter int V_SYNC = 6,
   parameter int V_BACK = 23
) (
   input  logic clock,
   input  logic reset,
   raster_if.source raster
);

   localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

   logic hblank, vblank;
   logic next_hblank, next_vblank;
   logic hblank_on, hsync_on, hsync_off, hreset;
   logic vblank_on, vsync_on, vsync_off, vreset;

   ////////////////////////////////////////////////////////////
   // horizontal events decoded one clock before they take effect
   assign hblank_on = raster.hcount == H_ACTIVE - 1;
   assign hsync_on = raster.hcount == H_ACTIVE + H_FRONT - 1;
   assign hsync_off = raster.hcount == H_ACTIVE + H_FRONT + H_SYNC - 1;
   assign hreset = raster.hcount == H_TOTAL - 1;

   // vertical events only count at the end of a line
   assign vblank_on = hreset && raster.vcount == V_ACTIVE - 1;
   assign vsync_on = hreset && raster.vcount == V_ACTIVE + V_FRONT - 1;
   assign vsync_off = hreset && raster.vcount == V_ACTIVE + V_FRONT + V_SYNC - 1;
   assign vreset = hreset && raster.vcount == V_TOTAL - 1;

   assign next_hblank = hreset ? 1'b0 : (hblank_on ? 1'b1 : hblank);
   assign next_vblank = vreset ? 1'b0 : (vblank_on ? 1'b1 : vblank);

   ////////////////////////////////////////////////////////////
   always_ff @(posedge clock) begin
      if (reset) begin
         raster.hcount <= '0;
         raster.vcount <= '0;
         raster.hsync <= 1'b1;
         raster.vsync <= 1'b1;
         raster.blank <= 1'b0;
         raster.frame_tick <= 1'b0;
         hblank <= 1'b0;
         vblank <= 1'b0;
      end else begin
         raster.hcount <= hreset ? '0 : raster.hcount + 1'b1;
         if (hreset) begin
            raster.vcount <= vreset ? '0 : raster.vcount + 1'b1;
         end
         raster.hsync <= hsync_on ? 1'b0 : (hsync_off ? 1'b1 : raster.hsync);
         raster.vsync <= vsync_on ? 1'b0 : (vsync_off ? 1'b1 : raster.vsync);
         hblank <= next_hblank;
         vblank <= next_vblank;
         // next-state flags let blank drop together with the line wrap
         raster.blank <= next_vblank | next_hblank;
         // same edge that takes vsync low
         raster.frame_tick <= vsync_on;
      end
   end

   assert property (@(posedge clock) disable iff (reset) raster.hcount < H_TOTAL);

endmodule

`default_nettype wire

//--- verilog/pong_physics.sv
// game physics, stepped once per frame
// paddle moves, puck motion, wall and paddle bounces, game over
`default_nettype none

module pong_physics #(
   parameter int H_ACTIVE = 1024,
   parameter int V_ACTIVE = 768,
   parameter int PADDLE_H = 128,
   parameter int PADDLE_W = 16,
   parameter int PADDLE_STEP = 4,
   parameter int PUCK_DIM = 64
) (
   input  logic clock,
   input  logic reset,
   input  logic [3:0] puck_speed,
   raster_if.sink raster,
   paddle_if.sink buttons,
   game_if.source game
);

   import pong_pkg::*;

   // start positions
   localparam vcoord_t PADDLE_Y0 = vcoord_t'(V_ACTIVE / 3);
   localparam hcoord_t PUCK_X0 = hcoord_t'(H_ACTIVE / 2 - PUCK_DIM / 2);
   localparam vcoord_t PUCK_Y0 = vcoord_t'(V_ACTIVE / 2 - PUCK_DIM / 2);
   // puck limits, left edges of the zones next to each paddle
   localparam hcoord_t X_HIT_LEFT = hcoord_t'(PADDLE_W);
   localparam hcoord_t X_HIT_RIGHT = hcoord_t'(H_ACTIVE - PADDLE_W - PUCK_DIM);
   localparam hcoord_t X_MAX = hcoord_t'(H_ACTIVE - PUCK_DIM);
   localparam vcoord_t Y_MAX = vcoord_t'(V_ACTIVE - PUCK_DIM);
   localparam vcoord_t STEP_V = vcoord_t'(PADDLE_STEP);

   vcoord_t paddle_y, paddle_2_y, puck_y;
   hcoord_t puck_x;
   hcoord_t speed_h;
   vcoord_t speed_v;
   // 1 = moving right, 1 = moving down
   logic x_vel, y_vel;
   logic game_over;
   logic hits_paddle, hits_paddle_2;

   assign speed_h = hcoord_t'(puck_speed);
   assign speed_v = vcoord_t'(puck_speed);

   // puck overlaps a paddle vertically
   assign hits_paddle = puck_y + PUCK_DIM > paddle_y && puck_y < paddle_y + PADDLE_H;
   assign hits_paddle_2 = puck_y + PUCK_DIM > paddle_2_y && puck_y < paddle_2_y + PADDLE_H;

   always_ff @(posedge clock) begin
      if (reset) begin
         paddle_y <= PADDLE_Y0;
         paddle_2_y <= PADDLE_Y0;
         puck_x <= PUCK_X0;
         puck_y <= PUCK_Y0;
         x_vel <= 1'b1;
         y_vel <= 1'b1;
         game_over <= 1'b0;
      end else if (raster.frame_tick && !game_over) begin
         ////////////////////////////////////////////////////////////
         // paddles, down wins over up
         if (buttons.down && paddle_y + PADDLE_STEP + PADDLE_H <= V_ACTIVE) begin
            paddle_y <= paddle_y + STEP_V;
         end else if (buttons.up && paddle_y >= PADDLE_STEP) begin
            paddle_y <= paddle_y - STEP_V;
         end
         if (buttons.right && paddle_2_y + PADDLE_STEP + PADDLE_H <= V_ACTIVE) begin
            paddle_2_y <= paddle_2_y + STEP_V;
         end else if (buttons.left && paddle_2_y >= PADDLE_STEP) begin
            paddle_2_y <= paddle_2_y - STEP_V;
         end

         ////////////////////////////////////////////////////////////
         // horizontal: bounce off a paddle or stop at the edge on a miss
         if (x_vel && puck_x >= X_HIT_RIGHT) begin
            if (hits_paddle_2) begin
               x_vel <= 1'b0;
               puck_x <= puck_x - speed_h;
            end else begin
               puck_x <= X_MAX;
               game_over <= 1'b1;
            end
         end else if (!x_vel && puck_x <= X_HIT_LEFT) begin
            if (hits_paddle) begin
               x_vel <= 1'b1;
               puck_x <= puck_x + speed_h;
            end else begin
               puck_x <= '0;
               game_over <= 1'b1;
            end
         end else begin
            puck_x <= x_vel ? puck_x + speed_h : puck_x - speed_h;
         end

         // vertical: clamp to the wall and turn around
         if (y_vel && puck_y + PUCK_DIM + puck_speed > V_ACTIVE) begin
            y_vel <= 1'b0;
            puck_y <= Y_MAX;
         end else if (!y_vel && puck_y < speed_v) begin
            y_vel <= 1'b1;
            puck_y <= '0;
         end else begin
            puck_y <= y_vel ? puck_y + speed_v : puck_y - speed_v;
         end
      end
   end

   assign game.paddle_y = paddle_y;
   assign game.paddle_2_y = paddle_2_y;
   assign game.puck_x = puck_x;
   assign game.puck_y = puck_y;

   // paddles stay on screen
   assert property (@(posedge clock) disable iff (reset)
      paddle_y + PADDLE_H <= V_ACTIVE && paddle_2_y + PADDLE_H <= V_ACTIVE);

endmodule

`default_nettype wire

//--- verilog/scene_renderer.sv
// scene renderer
// rectangle tests for paddles, puck and square, alpha blend, final pixel
`default_nettype none

module scene_renderer #(
   parameter int H_ACTIVE = 1024,
   parameter int V_ACTIVE = 768,
   parameter int PADDLE_H = 128,
   parameter int PADDLE_W = 16,
   parameter int PUCK_DIM = 64,
   parameter int SQUARE_DIM = 128
) (
   raster_if.sink raster,
   game_if.sink game,
   output pong_pkg::pixel_t pixel
);

   import pong_pkg::*;

   // square is fixed where the puck starts, centred on screen
   localparam int SQUARE_X = H_ACTIVE / 2 - SQUARE_DIM / 2;
   localparam int SQUARE_Y = V_ACTIVE / 2 - SQUARE_DIM / 2;

   pixel_t paddle_px, paddle_2_px, puck_px, square_px;
   pixel_t mix;

   // true when the raster position lies inside the w x h box at x0,y0
   function automatic logic in_rect(input int hc, input int vc, input int x0,
                                    input int y0, input int w, input int h);
      return hc >= x0 && hc < x0 + w && vc >= y0 && vc < y0 + h;
   endfunction

   assign paddle_px = in_rect(raster.hcount, raster.vcount, 0, game.paddle_y,
                              PADDLE_W, PADDLE_H) ? COLOR_PADDLE : '0;
   assign paddle_2_px = in_rect(raster.hcount, raster.vcount, H_ACTIVE - PADDLE_W,
                                game.paddle_2_y, PADDLE_W, PADDLE_H) ? COLOR_PADDLE : '0;
   assign puck_px = in_rect(raster.hcount, raster.vcount, game.puck_x, game.puck_y,
                            PUCK_DIM, PUCK_DIM) ? COLOR_PUCK : '0;
   assign square_px = in_rect(raster.hcount, raster.vcount, SQUARE_X, SQUARE_Y,
                              SQUARE_DIM, SQUARE_DIM) ? COLOR_SQUARE : '0;

   // per channel blend where puck and square overlap, plain OR elsewhere
   always_comb begin
      for (int c = 0; c < 3; c++) begin
         if (|puck_px && |square_px) begin
            mix[c*8 +: 8] = 8'((ALPHA * puck_px[c*8 +: 8] +
                                (256 - ALPHA) * square_px[c*8 +: 8]) / 256);
         end else begin
            mix[c*8 +: 8] = puck_px[c*8 +: 8] | square_px[c*8 +: 8];
         end
      end
   end

   // paddles sit on top, black while blanked
   assign pixel = raster.blank ? '0 : (paddle_px | paddle_2_px | mix);

endmodule

`default_nettype wire

//--- verilog/video_select.sv
// output side
// picks game, outline or colour bars and registers colour with syncs
`default_nettype none

module video_select #(
   parameter int H_ACTIVE = 1024,
   parameter int V_ACTIVE = 768,
   parameter int BAR_SHIFT = 6
) (
   input  logic clock,
   input  pong_pkg::source_mode_t mode,
   raster_if.sink raster,
   input  pong_pkg::pixel_t game_pixel,
   output pong_pkg::pixel_t rgb,
   output logic hsync,
   output logic vsync,
   output logic blank
);

   import pong_pkg::*;

   logic border;
   pixel_t bars;
   pixel_t selected;

   // first and last active column and row
   assign border = raster.hcount == 0 || raster.hcount == H_ACTIVE - 1 ||
                   raster.vcount == 0 || raster.vcount == V_ACTIVE - 1;

   // three hcount bits spread over red, green and blue
   assign bars = {{8{raster.hcount[BAR_SHIFT+2]}}, {8{raster.hcount[BAR_SHIFT+1]}},
                  {8{raster.hcount[BAR_SHIFT]}}};

   always_comb begin
      case (mode)
         SRC_OUTLINE: selected = raster.blank ? '0 : {24{border}};
         SRC_BARS: selected = raster.blank ? '0 : bars;
         default: selected = game_pixel;
      endcase
   end

   // one stage for colour and syncs alike keeps them aligned
   always_ff @(posedge clock) begin
      rgb <= selected;
      hsync <= raster.hsync;
      vsync <= raster.vsync;
      blank <= raster.blank;
   end

endmodule

`default_nettype wire

//--- verilog/pong_top.sv
// pong top level
// buttons, raster timing, physics, renderer and output stage
`default_nettype none

module pong_top #(
   parameter int H_ACTIVE = pong_pkg::H_ACTIVE_DEF,
   parameter int H_FRONT = pong_pkg::H_FRONT_DEF,
   parameter int H_SYNC = pong_pkg::H_SYNC_DEF,
   parameter int H_BACK = pong_pkg::H_BACK_DEF,
   parameter int V_ACTIVE = pong_pkg::V_ACTIVE_DEF,
   parameter int V_FRONT = pong_pkg::V_FRONT_DEF,
   parameter int V_SYNC = pong_pkg::V_SYNC_DEF,
   parameter int V_BACK = pong_pkg::V_BACK_DEF,
   parameter int PADDLE_H = pong_pkg::PADDLE_H_DEF,
   parameter int PADDLE_W = pong_pkg::PADDLE_W_DEF,
   parameter int PADDLE_STEP = pong_pkg::PADDLE_STEP_DEF,
   parameter int PUCK_DIM = pong_pkg::PUCK_DIM_DEF,
   parameter int SQUARE_DIM = pong_pkg::SQUARE_DIM_DEF,
   parameter int DEBOUNCE = pong_pkg::DEBOUNCE_DEF,
   parameter int BAR_SHIFT = pong_pkg::BAR_SHIFT_DEF
) (
   input  logic clock,
   input  logic reset,
   input  logic button_up_n,
   input  logic button_down_n,
   input  logic button_left_n,
   input  logic button_right_n,
   // 1:0 video source, 7:4 puck speed
   input  logic [7:0] switch,
   output logic [7:0] vga_red,
   output logic [7:0] vga_green,
   output logic [7:0] vga_blue,
   output logic vga_hsync,
   output logic vga_vsync,
   output logic vga_blank_n
);

   import pong_pkg::*;

   raster_if raster ();
   paddle_if paddles ();
   game_if game ();

   pixel_t game_pixel;
   pixel_t rgb;
   logic blank;

   paddle_buttons #(.DEBOUNCE(DEBOUNCE)) paddle_buttons_inst (
      .clock(clock),
      .reset(reset),
      .button_up_n(button_up_n),
      .button_down_n(button_down_n),
      .button_left_n(button_left_n),
      .button_right_n(button_right_n),
      .buttons(paddles)
   );

   raster_timing #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
   ) raster_timing_inst (
      .clock(clock),
      .reset(reset),
      .raster(raster)
   );

   pong_physics #(
      .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .PADDLE_H(PADDLE_H),
      .PADDLE_W(PADDLE_W), .PADDLE_STEP(PADDLE_STEP), .PUCK_DIM(PUCK_DIM)
   ) pong_physics_inst (
      .clock(clock),
      .reset(reset),
      .puck_speed(switch[7:4]),
      .raster(raster),
      .buttons(paddles),
      .game(game)
   );

   scene_renderer #(
      .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .PADDLE_H(PADDLE_H),
      .PADDLE_W(PADDLE_W), .PUCK_DIM(PUCK_DIM), .SQUARE_DIM(SQUARE_DIM)
   ) scene_renderer_inst (
      .raster(raster),
      .game(game),
      .pixel(game_pixel)
   );

   video_select #(
      .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .BAR_SHIFT(BAR_SHIFT)
   ) video_select_inst (
      .clock(clock),
      .mode(source_mode_t'(switch[1:0])),
      .raster(raster),
      .game_pixel(game_pixel),
      .rgb(rgb),
      .hsync(vga_hsync),
      .vsync(vga_vsync),
      .blank(blank)
   );

   assign vga_red = rgb[23:16];
   assign vga_green = rgb[15:8];
   assign vga_blue = rgb[7:0];
   assign vga_blank_n = ~blank;

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// testbench clock and power-on reset
// 100 unit clock period, reset held for the first 8 cycles
`default_nettype none

module tb_clock_gen (
   output logic clock,
   output logic reset
);

   initial begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   // released on a falling edge so the DUT sees a clean level
   initial begin
      reset = 1'b1;
      repeat (8) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

//--- verification/pong_checker.sv
// testbench monitor for the pong top level
// sync and blank timing checks, pixel position tracking, game model, pixel compare
`default_nettype none

module pong_checker #(
   parameter int H_ACTIVE = 32,
   parameter int H_TOTAL = 40,
   parameter int H_SYNC = 4,
   parameter int V_ACTIVE = 24,
   parameter int V_TOTAL = 32,
   parameter int PADDLE_H = 8,
   parameter int PADDLE_W = 4,
   parameter int PADDLE_STEP = 2,
   parameter int PUCK_DIM = 4,
   parameter int SQUARE_DIM = 8,
   parameter int BAR_SHIFT = 2
) (
   input  logic clock,
   input  logic reset,
   input  logic [7:0] switch,
   input  logic button_up_n,
   input  logic button_down_n,
   input  logic button_left_n,
   input  logic button_right_n,
   input  logic [7:0] vga_red,
   input  logic [7:0] vga_green,
   input  logic [7:0] vga_blue,
   input  logic vga_hsync,
   input  logic vga_vsync,
   input  logic vga_blank_n
);

   import pong_pkg::*;

   localparam int SQ_X = H_ACTIVE / 2 - SQUARE_DIM / 2;
   localparam int SQ_Y = V_ACTIVE / 2 - SQUARE_DIM / 2;

   string test_name = "startup";
   int error_count = 0;
   int check_count = 0;

   // inputs as the DUT saw them on the last rising edge
   logic reset_q;
   logic [7:0] sw_q;
   // pressed levels {up, down, left, right}
   logic [3:0] btn_q;

   // game model
   int m_pad, m_pad_2, m_px, m_py;
   logic m_right, m_down, m_over;

   // raster tracking
   logic prev_hsync, prev_vsync, prev_blank_n;
   int h_period, h_low, v_period, active_run;
   logic h_seen, v_seen, run_seen;
   int x, y;
   logic new_frame, y_valid;
   pixel_t rgb, expect_rgb;

   always @(posedge clock) begin
      reset_q <= reset;
      sw_q <= switch;
      btn_q <= ~{button_up_n, button_down_n, button_left_n, button_right_n};
   end

   task automatic compare(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("FAIL %s %s: expected %h actual %h", test_name, what, expected, actual);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // game rules stepped once per frame
   task automatic reset_model();
      m_pad = V_ACTIVE / 3;
      m_pad_2 = V_ACTIVE / 3;
      m_px = H_ACTIVE / 2 - PUCK_DIM / 2;
      m_py = V_ACTIVE / 2 - PUCK_DIM / 2;
      m_right = 1'b1;
      m_down = 1'b1;
      m_over = 1'b0;
   endtask

   task automatic step_model(input int s, input logic [3:0] b);
      logic hit_1, hit_2;
      // overlap uses paddle rows from before this frame's move
      hit_1 = m_py + PUCK_DIM > m_pad && m_py < m_pad + PADDLE_H;
      hit_2 = m_py + PUCK_DIM > m_pad_2 && m_py < m_pad_2 + PADDLE_H;
      if (m_over) begin
         return;
      end
      if (b[2] && m_pad + PADDLE_STEP + PADDLE_H <= V_ACTIVE) begin
         m_pad += PADDLE_STEP;
      end else if (b[3] && m_pad >= PADDLE_STEP) begin
         m_pad -= PADDLE_STEP;
      end
      if (b[0] && m_pad_2 + PADDLE_STEP + PADDLE_H <= V_ACTIVE) begin
         m_pad_2 += PADDLE_STEP;
      end else if (b[1] && m_pad_2 >= PADDLE_STEP) begin
         m_pad_2 -= PADDLE_STEP;
      end
      if (m_right && m_px >= H_ACTIVE - PADDLE_W - PUCK_DIM) begin
         if (hit_2) begin
            m_right = 1'b0;
            m_px -= s;
         end else begin
            m_px = H_ACTIVE - PUCK_DIM;
            m_over = 1'b1;
            $display("model: right paddle missed, puck stops at x %0d", m_px);
         end
      end else if (!m_right && m_px <= PADDLE_W) begin
         if (hit_1) begin
            m_right = 1'b1;
            m_px += s;
         end else begin
            m_px = 0;
            m_over = 1'b1;
            $display("model: left paddle missed, puck stops at x 0");
         end
      end else begin
         m_px = m_right ? m_px + s : m_px - s;
      end
      if (m_down && m_py + PUCK_DIM + s > V_ACTIVE) begin
         m_down = 1'b0;
         m_py = V_ACTIVE - PUCK_DIM;
      end else if (!m_down && m_py < s) begin
         m_down = 1'b1;
         m_py = 0;
      end else begin
         m_py = m_down ? m_py + s : m_py - s;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // expected colours
   function automatic logic inside_box(input int px, input int py, input int x0,
                                       input int y0, input int w, input int h);
      return px >= x0 && px < x0 + w && py >= y0 && py < y0 + h;
   endfunction

   function automatic logic [7:0] blend(input int p, input int s);
      return 8'((ALPHA * p + (256 - ALPHA) * s) / 256);
   endfunction

   function automatic pixel_t scene_pixel(input int px, input int py);
      pixel_t puck, square, result;
      logic on_paddle;
      puck = inside_box(px, py, m_px, m_py, PUCK_DIM, PUCK_DIM) ? COLOR_PUCK : '0;
      square = inside_box(px, py, SQ_X, SQ_Y, SQUARE_DIM, SQUARE_DIM) ? COLOR_SQUARE : '0;
      if (puck != 0 && square != 0) begin
         result = {blend(puck[23:16], square[23:16]), blend(puck[15:8], square[15:8]),
                   blend(puck[7:0], square[7:0])};
      end else begin
         result = puck | square;
      end
      on_paddle = inside_box(px, py, 0, m_pad, PADDLE_W, PADDLE_H) ||
                  inside_box(px, py, H_ACTIVE - PADDLE_W, m_pad_2, PADDLE_W, PADDLE_H);
      return on_paddle ? (result | COLOR_PADDLE) : result;
   endfunction

   function automatic pixel_t expected_pixel(input logic [1:0] mode, input int px,
                                             input int py);
      logic [2:0] bar;
      bar = 3'(px >> BAR_SHIFT);
      case (mode)
         2'b01: return (px == 0 || px == H_ACTIVE - 1 || py == 0 || py == V_ACTIVE - 1) ?
                       24'hFFFFFF : 24'h000000;
         2'b10: return {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
         default: return scene_pixel(px, py);
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // outputs are sampled on the falling edge half a cycle after they change
   always @(negedge clock) begin
      rgb = {vga_red, vga_green, vga_blue};
      if (reset_q) begin
         reset_model();
         h_seen = 1'b0;
         v_seen = 1'b0;
         run_seen = 1'b0;
         new_frame = 1'b0;
         y_valid = 1'b0;
      end else begin
         h_period++;
         v_period++;
         if (!vga_hsync) h_low++;
         if (vga_blank_n) active_run++;
         if (prev_hsync && !vga_hsync) begin
            if (h_seen) compare("hsync period", H_TOTAL, h_period);
            h_seen = 1'b1;
            h_period = 0;
            h_low = 1;
         end
         if (!prev_hsync && vga_hsync && h_seen) begin
            compare("hsync low width", H_SYNC, h_low);
         end
         // the DUT steps its game on the same edge that drops vsync here
         if (prev_vsync && !vga_vsync) begin
            if (v_seen) compare("vsync period", H_TOTAL * V_TOTAL, v_period);
            v_seen = 1'b1;
            v_period = 0;
            step_model(int'(sw_q[7:4]), btn_q);
         end
         if (!prev_vsync && vga_vsync) new_frame = 1'b1;
         if (prev_blank_n && !vga_blank_n && run_seen) begin
            compare("active pixels per line", H_ACTIVE, active_run);
         end
         if (!prev_blank_n && vga_blank_n) begin
            run_seen = 1'b1;
            active_run = 1;
            x = 0;
            if (new_frame) begin
               y = 0;
               new_frame = 1'b0;
               y_valid = 1'b1;
            end else begin
               y++;
            end
         end else if (vga_blank_n) begin
            x++;
         end
         if (y_valid) begin
            expect_rgb = vga_blank_n ? expected_pixel(sw_q[1:0], x, y) : '0;
            compare($sformatf("pixel x %0d y %0d", x, y), expect_rgb, rgb);
         end
      end
      prev_hsync = vga_hsync;
      prev_vsync = vga_vsync;
      prev_blank_n = vga_blank_n;
   end

endmodule

`default_nettype wire

//--- verification/pong_tb.sv
// top testbench for pong_top on a 32x24 screen
// stimulus table, falling-edge driver, random puck speed, watchdog
`default_nettype none

module pong_tb;

   localparam int H_ACTIVE = 32;
   localparam int H_PORCH = 2;
   localparam int H_SYNC = 4;
   localparam int V_ACTIVE = 24;
   localparam int V_SYNC = 4;
   localparam int H_TOTAL = H_ACTIVE + 2 * H_PORCH + H_SYNC;
   localparam int V_TOTAL = V_ACTIVE + 2 * H_PORCH + V_SYNC;
   localparam int ROWS = 7;

   logic clock, gen_reset, row_reset, reset;
   logic button_up_n, button_down_n, button_left_n, button_right_n;
   logic [7:0] switch;
   logic [7:0] vga_red, vga_green, vga_blue;
   logic vga_hsync, vga_vsync, vga_blank_n;

   ////////////////////////////////////////////////////////////
   // test table: name, reset first, mode, random speed, buttons {up,down,left,right}, frames
   string name_tab [ROWS] = '{"outline", "bars", "reset_scene", "paddle_down",
                              "paddle_up", "puck_motion", "game_over"};
   logic reset_tab [ROWS] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
   logic [1:0] mode_tab [ROWS] = '{2'b01, 2'b10, 2'b00, 2'b00, 2'b00, 2'b00, 2'b00};
   logic rand_tab [ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
   logic [3:0] button_tab [ROWS] = '{4'b0000, 4'b0000, 4'b0000, 4'b0101,
                                     4'b1010, 4'b0000, 4'b1010};
   int frame_tab [ROWS] = '{2, 2, 2, 10, 12, 8, 30};

   logic [31:0] rand_state = 32'h3104eaae;
   logic [3:0] speed;
   int total_frames;

   assign reset = gen_reset | row_reset;

   tb_clock_gen clock_gen_inst (
      .clock(clock),
      .reset(gen_reset)
   );

   pong_top #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_PORCH), .H_SYNC(H_SYNC), .H_BACK(H_PORCH),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(H_PORCH), .V_SYNC(V_SYNC), .V_BACK(H_PORCH),
      .PADDLE_H(8), .PADDLE_W(4), .PADDLE_STEP(2), .PUCK_DIM(4), .SQUARE_DIM(8),
      .DEBOUNCE(3), .BAR_SHIFT(2)
   ) pong_top_inst (
      .clock(clock),
      .reset(reset),
      .button_up_n(button_up_n),
      .button_down_n(button_down_n),
      .button_left_n(button_left_n),
      .button_right_n(button_right_n),
      .switch(switch),
      .vga_red(vga_red),
      .vga_green(vga_green),
      .vga_blue(vga_blue),
      .vga_hsync(vga_hsync),
      .vga_vsync(vga_vsync),
      .vga_blank_n(vga_blank_n)
   );

   pong_checker #(
      .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC), .V_ACTIVE(V_ACTIVE),
      .V_TOTAL(V_TOTAL), .PADDLE_H(8), .PADDLE_W(4), .PADDLE_STEP(2), .PUCK_DIM(4),
      .SQUARE_DIM(8), .BAR_SHIFT(2)
   ) checker_inst (
      .clock(clock), .reset(reset), .switch(switch),
      .button_up_n(button_up_n), .button_down_n(button_down_n),
      .button_left_n(button_left_n), .button_right_n(button_right_n),
      .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue),
      .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_blank_n(vga_blank_n)
   );

   // linear congruential step
   function automatic logic [31:0] next_random(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic wait_frames(input int count);
      repeat (count) @(negedge vga_vsync);
      @(negedge clock);
   endtask

   initial begin
      row_reset = 1'b0;
      switch = 8'h00;
      {button_up_n, button_down_n, button_left_n, button_right_n} = 4'b1111;
      wait (!gen_reset);
      @(negedge clock);
      for (int i = 0; i < ROWS; i++) begin
         speed = 4'd0;
         if (rand_tab[i]) begin
            rand_state = next_random(rand_state);
            speed = 4'(1 + (rand_state >> 16) % 3);
         end
         checker_inst.test_name = name_tab[i];
         $display("test %s, speed %0d, %0d frames", name_tab[i], speed, frame_tab[i]);
         switch = {speed, 2'b00, mode_tab[i]};
         {button_up_n, button_down_n, button_left_n, button_right_n} = ~button_tab[i];
         if (reset_tab[i]) begin
            row_reset = 1'b1;
            repeat (3) @(negedge clock);
            row_reset = 1'b0;
         end
         wait_frames(frame_tab[i]);
      end
      $display("checks %0d, errors %0d", checker_inst.check_count,
               checker_inst.error_count);
      if (checker_inst.error_count == 0 && checker_inst.check_count > 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // limit is twice the table's total frame time
   initial begin
      total_frames = 0;
      for (int i = 0; i < ROWS; i++) total_frames += frame_tab[i];
      #(longint'(total_frames) * H_TOTAL * V_TOTAL * 2 * 100);
      $display("watchdog: simulation ran past its time limit, the DUT stopped making frames");
      $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
verilog/pong_pkg.sv
verilog/pong_interfaces.sv
verilog/button_debounce.sv
verilog/paddle_buttons.sv
verilog/raster_timing.sv
verilog/pong_physics.sv
verilog/scene_renderer.sv
verilog/video_select.sv
verilog/pong_top.sv
verification/tb_clock_gen.sv
verification/pong_checker.sv
verification/pong_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pong testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module pong_tb -o pong_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/pong_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Verification passed$" sim.log; then
   exit 0
fi
exit 1
